// ==== source/pool_consts.svh ====
`ifndef POOL_CONSTS_SVH
`define POOL_CONSTS_SVH

// Word and address widths of the DMA ports
`define POOL_DATA_W 16
`define POOL_ADDR_W 30

// Read-return FIFO depth, also the read credit count
`define POOL_RD_DEPTH 4

// Result FIFO between reducer and writer
`define POOL_RES_DEPTH 4

// Write credits granted by the DMA after reset
`define POOL_WR_CREDITS 2

`endif

// ==== source/pool_pkg.sv ====
`include "pool_consts.svh"

package pool_pkg;

	// Feature-map word, IEEE half precision
	typedef logic [`POOL_DATA_W-1:0] fp16_t;

	// DMA word address
	typedef logic [`POOL_ADDR_W-1:0] addr_t;

	// Side length, kernel size or stride
	typedef logic [7:0] side_t;

	typedef logic [15:0] chan_t;

	typedef enum logic [2:0] {
		CONV     = 3'd1,
		MAX_POOL = 3'd4,
		AVG_POOL = 3'd5
	} op_t;

	typedef enum logic [1:0] {
		IDLE,
		CHECK,
		RUN,
		DONE
	} dec_state_t;

endpackage

// ==== source/pool_sync_fifo.sv ====
`timescale 1ns/1ns

module pool_sync_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 16
) (
	input  logic                       clk,
	input  logic                       i_rst,
	input  logic                       i_push,
	input  logic [WIDTH-1:0]           i_data,
	input  logic                       i_pop,
	output logic [WIDTH-1:0]           o_data,
	output logic                       o_empty,
	output logic                       o_full,
	output logic [$clog2(DEPTH+1)-1:0] o_count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;
	assign o_empty = (o_count == '0);
	assign o_full = (o_count == ($clog2(DEPTH+1))'(DEPTH));
	// Head word is visible without a read cycle
	assign o_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: o_count <= o_count + 1'b1;
				2'b01: o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

endmodule

// ==== source/pool_cmd_decode.sv ====
`timescale 1ns/1ns

module pool_cmd_decode (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_start,
	input  pool_pkg::op_t      i_op,
	input  pool_pkg::side_t    i_kernel,
	input  pool_pkg::side_t    i_stride,
	input  pool_pkg::side_t    i_side,
	input  pool_pkg::chan_t    i_channels,
	input  pool_pkg::addr_t    i_src_addr,
	input  pool_pkg::addr_t    i_dst_addr,
	input  logic               i_all_written,
	output logic               o_go,
	output pool_pkg::side_t    o_kernel,
	output pool_pkg::side_t    o_stride,
	output pool_pkg::side_t    o_side,
	output pool_pkg::side_t    o_out_side,
	output pool_pkg::chan_t    o_channels,
	output pool_pkg::addr_t    o_src_addr,
	output pool_pkg::addr_t    o_dst_addr,
	output logic               o_busy,
	output logic               o_done,
	output logic               o_op_error
);

	pool_pkg::dec_state_t state;
	pool_pkg::op_t op;
	logic err;
	logic bad;
	logic fits;
	// Start of the next window along one axis
	logic [8:0] pos;

	assign bad = (op != pool_pkg::MAX_POOL) || (o_kernel == 8'd0) || (o_stride == 8'd0) ||
		(o_channels == 16'd0) || (o_kernel > o_side);
	assign fits = ({1'b0, pos} + {2'b00, o_kernel}) <= {2'b00, o_side};

	assign o_busy = (state == pool_pkg::CHECK) || (state == pool_pkg::RUN);
	assign o_done = (state == pool_pkg::DONE);
	assign o_op_error = (state == pool_pkg::DONE) && err;
	// Window count is final once the next window no longer fits
	assign o_go = (state == pool_pkg::CHECK) && !bad && !fits;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= pool_pkg::IDLE;
			err <= 1'b0;
			pos <= 9'd0;
			o_out_side <= 8'd0;
		end else begin
			case (state)
				pool_pkg::IDLE, pool_pkg::DONE: begin
					if (i_start) begin
						state <= pool_pkg::CHECK;
						err <= 1'b0;
						pos <= 9'd0;
						o_out_side <= 8'd0;
					end else begin
						state <= pool_pkg::IDLE;
					end
				end
				pool_pkg::CHECK: begin
					if (bad) begin
						err <= 1'b1;
						state <= pool_pkg::DONE;
					end else if (fits) begin
						pos <= pos + {1'b0, o_stride};
						o_out_side <= o_out_side + 8'd1;
					end else begin
						state <= pool_pkg::RUN;
					end
				end
				pool_pkg::RUN: begin
					if (i_all_written)
						state <= pool_pkg::DONE;
				end
				default: state <= pool_pkg::IDLE;
			endcase
		end
	end

	// Command fields, held for the whole command
	always_ff @(posedge clk) begin
		if (i_start && !o_busy) begin
			op <= i_op;
			o_kernel <= i_kernel;
			o_stride <= i_stride;
			o_side <= i_side;
			o_channels <= i_channels;
			o_src_addr <= i_src_addr;
			o_dst_addr <= i_dst_addr;
		end
	end

endmodule

// ==== source/pool_window_exec.sv ====
`timescale 1ns/1ns
`include "pool_consts.svh"

module pool_window_exec (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_go,
	input  pool_pkg::side_t    i_kernel,
	input  pool_pkg::side_t    i_stride,
	input  pool_pkg::side_t    i_side,
	input  pool_pkg::side_t    i_out_side,
	input  pool_pkg::chan_t    i_channels,
	input  pool_pkg::addr_t    i_src_addr,
	input  logic               i_rd_valid,
	input  pool_pkg::fp16_t    i_rd_data,
	input  logic               i_res_full,
	output logic               o_rd_req,
	output pool_pkg::addr_t    o_rd_addr,
	output logic               o_res_push,
	output pool_pkg::fp16_t    o_res_data
);

	localparam int CNT_W = $clog2(`POOL_RD_DEPTH+1);

	logic walk;
	pool_pkg::side_t oy, ox, ky, kx;
	pool_pkg::chan_t ch;
	logic [15:0] row_y;
	logic [15:0] col_x;
	logic [31:0] pix;
	logic [31:0] word_off;
	logic [CNT_W-1:0] pend;
	logic [CNT_W-1:0] rd_count;
	logic rd_empty;
	pool_pkg::fp16_t rd_word;
	logic pop;
	logic [15:0] ksq;
	logic [15:0] taken;
	logic first;
	logic last;
	pool_pkg::fp16_t run_max;
	pool_pkg::fp16_t cand_max;

	// Maps a half-precision value to an unsigned key with the same order
	function automatic logic [15:0] order_key(input pool_pkg::fp16_t w);
		logic [15:0] k;
		if (w[14:0] == 15'd0)
			k = 16'h8000;
		else if (w[15])
			k = ~w;
		else
			k = {1'b1, w[14:0]};
		return k;
	endfunction

	assign row_y = {8'd0, oy} * {8'd0, i_stride} + {8'd0, ky};
	assign col_x = {8'd0, ox} * {8'd0, i_stride} + {8'd0, kx};
	assign pix = {16'd0, row_y} * {24'd0, i_side} + {16'd0, col_x};
	assign word_off = pix * {16'd0, i_channels} + {16'd0, ch};
	assign o_rd_addr = i_src_addr + word_off[`POOL_ADDR_W-1:0];

	// Credits cover words in flight and words already buffered
	assign o_rd_req = walk &&
		(({1'b0, pend} + {1'b0, rd_count}) < (CNT_W+1)'(`POOL_RD_DEPTH));

	always_ff @(posedge clk) begin
		if (i_rst) begin
			walk <= 1'b0;
			oy <= 8'd0;
			ox <= 8'd0;
			ch <= 16'd0;
			ky <= 8'd0;
			kx <= 8'd0;
		end else if (i_go) begin
			walk <= 1'b1;
			oy <= 8'd0;
			ox <= 8'd0;
			ch <= 16'd0;
			ky <= 8'd0;
			kx <= 8'd0;
		end else if (o_rd_req) begin
			if (kx == i_kernel - 8'd1) begin
				kx <= 8'd0;
				if (ky == i_kernel - 8'd1) begin
					ky <= 8'd0;
					if (ch == i_channels - 16'd1) begin
						ch <= 16'd0;
						if (ox == i_out_side - 8'd1) begin
							ox <= 8'd0;
							if (oy == i_out_side - 8'd1) begin
								oy <= 8'd0;
								walk <= 1'b0;
							end else begin
								oy <= oy + 8'd1;
							end
						end else begin
							ox <= ox + 8'd1;
						end
					end else begin
						ch <= ch + 16'd1;
					end
				end else begin
					ky <= ky + 8'd1;
				end
			end else begin
				kx <= kx + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			pend <= '0;
		end else begin
			case ({o_rd_req, i_rd_valid})
				2'b10: pend <= pend + 1'b1;
				2'b01: pend <= pend - 1'b1;
				default: pend <= pend;
			endcase
		end
	end

	pool_sync_fifo #(
		.DEPTH (`POOL_RD_DEPTH),
		.WIDTH (`POOL_DATA_W)
	) rd_fifo_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_push  (i_rd_valid),
		.i_data  (i_rd_data),
		.i_pop   (pop),
		.o_data  (rd_word),
		.o_empty (rd_empty),
		.o_full  (),
		.o_count (rd_count)
	);

	// Reducer
	assign ksq = {8'd0, i_kernel} * {8'd0, i_kernel};
	assign pop = !rd_empty && !i_res_full;
	assign first = (taken == 16'd0);
	assign last = (taken == ksq - 16'd1);
	// Strictly greater replaces, so ties keep the earlier word
	assign cand_max = (first || (order_key(rd_word) > order_key(run_max))) ? rd_word : run_max;
	assign o_res_push = pop && last;
	assign o_res_data = cand_max;

	always_ff @(posedge clk) begin
		if (i_rst || i_go)
			taken <= 16'd0;
		else if (pop)
			taken <= last ? 16'd0 : taken + 16'd1;
	end

	always_ff @(posedge clk) begin
		if (pop)
			run_max <= cand_max;
	end

endmodule

// ==== source/pool_result_writer.sv ====
`timescale 1ns/1ns
`include "pool_consts.svh"

module pool_result_writer (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_go,
	input  pool_pkg::addr_t    i_dst_addr,
	input  pool_pkg::side_t    i_out_side,
	input  pool_pkg::chan_t    i_channels,
	input  logic               i_res_push,
	input  pool_pkg::fp16_t    i_res_data,
	input  logic               i_wr_credit,
	output logic               o_res_full,
	output logic               o_wr_valid,
	output pool_pkg::addr_t    o_wr_addr,
	output pool_pkg::fp16_t    o_wr_data,
	output logic               o_all_written
);

	logic res_empty;
	logic [3:0] credits;
	logic [31:0] idx;
	logic [31:0] total;

	pool_sync_fifo #(
		.DEPTH (`POOL_RES_DEPTH),
		.WIDTH (`POOL_DATA_W)
	) res_fifo_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_push  (i_res_push),
		.i_data  (i_res_data),
		.i_pop   (o_wr_valid),
		.o_data  (o_wr_data),
		.o_empty (res_empty),
		.o_full  (o_res_full),
		.o_count ()
	);

	assign total = ({24'd0, i_out_side} * {24'd0, i_out_side}) * {16'd0, i_channels};
	assign o_wr_valid = !res_empty && (credits != 4'd0);
	assign o_wr_addr = i_dst_addr + idx[`POOL_ADDR_W-1:0];
	// Flags the last word in the cycle it goes out
	assign o_all_written = o_wr_valid && (idx == total - 32'd1);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			credits <= 4'(`POOL_WR_CREDITS);
		end else begin
			case ({o_wr_valid, i_wr_credit})
				2'b10: credits <= credits - 4'd1;
				2'b01: credits <= credits + 4'd1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst || i_go)
			idx <= 32'd0;
		else if (o_wr_valid)
			idx <= idx + 32'd1;
	end

endmodule

// ==== source/pool_engine.sv ====
`timescale 1ns/1ns

module pool_engine (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_start,
	input  pool_pkg::op_t      i_op,
	input  pool_pkg::side_t    i_kernel,
	input  pool_pkg::side_t    i_stride,
	input  pool_pkg::side_t    i_side,
	input  pool_pkg::chan_t    i_channels,
	input  pool_pkg::addr_t    i_src_addr,
	input  pool_pkg::addr_t    i_dst_addr,
	output logic               o_busy,
	output logic               o_done,
	output logic               o_op_error,
	output logic               o_rd_req,
	output pool_pkg::addr_t    o_rd_addr,
	input  logic               i_rd_valid,
	input  pool_pkg::fp16_t    i_rd_data,
	output logic               o_wr_valid,
	output pool_pkg::addr_t    o_wr_addr,
	output pool_pkg::fp16_t    o_wr_data,
	input  logic               i_wr_credit
);

	logic go;
	pool_pkg::side_t kernel, stride, side, out_side;
	pool_pkg::chan_t channels;
	pool_pkg::addr_t src_addr, dst_addr;
	logic all_written;
	logic res_push;
	pool_pkg::fp16_t res_data;
	logic res_full;

	pool_cmd_decode decode_i (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_start       (i_start),
		.i_op          (i_op),
		.i_kernel      (i_kernel),
		.i_stride      (i_stride),
		.i_side        (i_side),
		.i_channels    (i_channels),
		.i_src_addr    (i_src_addr),
		.i_dst_addr    (i_dst_addr),
		.i_all_written (all_written),
		.o_go          (go),
		.o_kernel      (kernel),
		.o_stride      (stride),
		.o_side        (side),
		.o_out_side    (out_side),
		.o_channels    (channels),
		.o_src_addr    (src_addr),
		.o_dst_addr    (dst_addr),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_op_error    (o_op_error)
	);

	pool_window_exec exec_i (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_go       (go),
		.i_kernel   (kernel),
		.i_stride   (stride),
		.i_side     (side),
		.i_out_side (out_side),
		.i_channels (channels),
		.i_src_addr (src_addr),
		.i_rd_valid (i_rd_valid),
		.i_rd_data  (i_rd_data),
		.i_res_full (res_full),
		.o_rd_req   (o_rd_req),
		.o_rd_addr  (o_rd_addr),
		.o_res_push (res_push),
		.o_res_data (res_data)
	);

	pool_result_writer writer_i (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_go          (go),
		.i_dst_addr    (dst_addr),
		.i_out_side    (out_side),
		.i_channels    (channels),
		.i_res_push    (res_push),
		.i_res_data    (res_data),
		.i_wr_credit   (i_wr_credit),
		.o_res_full    (res_full),
		.o_wr_valid    (o_wr_valid),
		.o_wr_addr     (o_wr_addr),
		.o_wr_data     (o_wr_data),
		.o_all_written (all_written)
	);

endmodule

// ==== tests/pool_dma_model.sv ====
`timescale 1ns/1ns

module pool_dma_model (
	input  logic            clk,
	input  logic            i_rst,
	input  logic            i_throttle,
	input  logic            i_rd_req,
	input  pool_pkg::addr_t i_rd_addr,
	output logic            o_rd_valid,
	output pool_pkg::fp16_t o_rd_data,
	input  logic            i_wr_valid,
	input  pool_pkg::addr_t i_wr_addr,
	input  pool_pkg::fp16_t i_wr_data,
	output logic            o_wr_credit
);

	pool_pkg::fp16_t mem [1024];
	pool_pkg::fp16_t res_mem [1024];
	int wr_cnt [1024];
	pool_pkg::addr_t rd_q [$];
	int rd_due [$];
	int cr_due [$];
	int cycle;
	integer seed;
	pool_pkg::addr_t a;

	initial begin
		seed = 73;
		cycle = 0;
		o_rd_valid = 1'b0;
		o_rd_data = '0;
		o_wr_credit = 1'b0;
	end

	// Requests and writes taken at the falling edge
	always @(negedge clk) begin
		if (!i_rst && i_rd_req) begin
			rd_q.push_back(i_rd_addr);
			rd_due.push_back(cycle + 1 + $unsigned($random(seed)) % 6);
		end
		if (!i_rst && i_wr_valid) begin
			res_mem[i_wr_addr[9:0]] = i_wr_data;
			wr_cnt[i_wr_addr[9:0]] += 1;
			cr_due.push_back(cycle + 1 + $unsigned($random(seed)) % 9);
		end
	end

	// Throttled: credits held back for 64 of every 80 cycles
	always @(posedge clk) begin
		#2;
		cycle = cycle + 1;
		o_rd_valid = 1'b0;
		o_wr_credit = 1'b0;
		if (i_rst) begin
			rd_q.delete();
			rd_due.delete();
			cr_due.delete();
		end else begin
			// Words come back in request order
			if (rd_q.size() > 0 && rd_due[0] <= cycle) begin
				a = rd_q.pop_front();
				void'(rd_due.pop_front());
				o_rd_valid = 1'b1;
				o_rd_data = mem[a[9:0]];
			end
			if (cr_due.size() > 0 && cr_due[0] <= cycle && !(i_throttle && cycle % 80 < 64)) begin
				void'(cr_due.pop_front());
				o_wr_credit = 1'b1;
			end
		end
	end

endmodule

// ==== tests/pool_engine_tb.sv ====
`timescale 1ns/1ns
`include "pool_consts.svh"

module pool_engine_tb;

	localparam int TIMEOUT = 20000;

	logic clk;
	logic rst;
	logic start;
	pool_pkg::op_t op;
	pool_pkg::side_t kernel;
	pool_pkg::side_t stride;
	pool_pkg::side_t side;
	pool_pkg::chan_t channels;
	pool_pkg::addr_t src_addr;
	pool_pkg::addr_t dst_addr;
	logic busy;
	logic done;
	logic op_error;
	logic rd_req;
	pool_pkg::addr_t rd_addr;
	logic rd_valid;
	pool_pkg::fp16_t rd_data;
	logic wr_valid;
	pool_pkg::addr_t wr_addr;
	pool_pkg::fp16_t wr_data;
	logic wr_credit;
	logic throttle;

	int value_errs;
	int proto_errs;
	int held;
	int outstanding;
	int reads;
	int writes;
	int done_cnt;
	int ksq;
	pool_pkg::addr_t next_wr;
	logic stalled;
	int n;
	int d0;
	int cur_src;
	int cur_sd;
	int cur_ch;
	int cur_k;
	int cur_s;

	pool_engine dut_i (
		.clk         (clk),
		.i_rst       (rst),
		.i_start     (start),
		.i_op        (op),
		.i_kernel    (kernel),
		.i_stride    (stride),
		.i_side      (side),
		.i_channels  (channels),
		.i_src_addr  (src_addr),
		.i_dst_addr  (dst_addr),
		.o_busy      (busy),
		.o_done      (done),
		.o_op_error  (op_error),
		.o_rd_req    (rd_req),
		.o_rd_addr   (rd_addr),
		.i_rd_valid  (rd_valid),
		.i_rd_data   (rd_data),
		.o_wr_valid  (wr_valid),
		.o_wr_addr   (wr_addr),
		.o_wr_data   (wr_data),
		.i_wr_credit (wr_credit)
	);

	pool_dma_model dma_i (
		.clk         (clk),
		.i_rst       (rst),
		.i_throttle  (throttle),
		.i_rd_req    (rd_req),
		.i_rd_addr   (rd_addr),
		.o_rd_valid  (rd_valid),
		.o_rd_data   (rd_data),
		.i_wr_valid  (wr_valid),
		.i_wr_addr   (wr_addr),
		.i_wr_data   (wr_data),
		.o_wr_credit (wr_credit)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Hashed fill with some signed zeros and no NaN or infinity codes
	function automatic pool_pkg::fp16_t map_word(input int a);
		logic [31:0] h;
		h = (a ^ 32'h5bd1) * 32'd2654435761;
		if (h[3:0] == 4'd0)
			return {h[31], 15'd0};
		if (h[30:26] == 5'h1f)
			h[30] = 1'b0;
		return h[31:16];
	endfunction

	// Sign-magnitude order with both zeros equal
	function automatic logic is_above(input pool_pkg::fp16_t a, input pool_pkg::fp16_t b);
		logic a_neg;
		logic b_neg;
		a_neg = a[15] && (a[14:0] != 15'd0);
		b_neg = b[15] && (b[14:0] != 15'd0);
		if (a_neg != b_neg)
			return b_neg;
		if (a_neg)
			return a[14:0] < b[14:0];
		return a[14:0] > b[14:0];
	endfunction

	function automatic pool_pkg::fp16_t ref_max(input int src, input int sd, input int ch,
		input int k, input int s, input int oy, input int ox, input int c);
		pool_pkg::fp16_t best;
		pool_pkg::fp16_t w;
		int ky;
		int kx;
		best = '0;
		for (ky = 0; ky < k; ky++) begin
			for (kx = 0; kx < k; kx++) begin
				w = dma_i.mem[src + ((oy * s + ky) * sd + ox * s + kx) * ch + c];
				// Earlier word survives a tie
				if ((ky == 0 && kx == 0) || is_above(w, best))
					best = w;
			end
		end
		return best;
	endfunction

	// Source address of read number r, walking row, column, channel, kernel row, kernel column
	function automatic int read_addr(input int r);
		int os;
		int w;
		int pix;
		os = (cur_sd - cur_k) / cur_s + 1;
		w = r / (cur_k * cur_k);
		pix = w / cur_ch;
		return cur_src + (((pix / os) * cur_s + (r / cur_k) % cur_k) * cur_sd +
			(pix % os) * cur_s + r % cur_k) * cur_ch + w % cur_ch;
	endfunction

	always @(negedge clk) begin
		if (rst) begin
			held = `POOL_WR_CREDITS;
			outstanding = 0;
		end else begin
			assert (!wr_valid || held > 0) else begin
				proto_errs++;
				$display("write sent with no write credit held at %0t ns", $time);
			end
			assert (!rd_req || outstanding < `POOL_RD_DEPTH) else begin
				proto_errs++;
				$display("read requested with no read credit at %0t ns", $time);
			end
			assert (!rd_req || rd_addr == 30'(read_addr(reads))) else begin
				value_errs++;
				$display("error %0t ns o_rd_addr: got %h, expected %h", $time, rd_addr,
					30'(read_addr(reads)));
			end
			assert (reads - ksq * writes <= `POOL_RD_DEPTH + ksq * (`POOL_RES_DEPTH + 1)) else begin
				proto_errs++;
				$display("reads kept going under write back-pressure at %0t ns", $time);
			end
			assert (!wr_valid || wr_addr == next_wr) else begin
				value_errs++;
				$display("error %0t ns o_wr_addr: got %h, expected %h", $time, wr_addr, next_wr);
			end
			assert (!op_error || done) else begin
				proto_errs++;
				$display("o_op_error raised without o_done at %0t ns", $time);
			end
			held = held - int'(wr_valid) + int'(wr_credit);
			outstanding = outstanding + int'(rd_req) - int'(rd_valid);
			reads = reads + int'(rd_req);
			if (wr_valid) begin
				writes++;
				next_wr = next_wr + 1;
			end
			done_cnt = done_cnt + int'(done);
		end
	end

	task automatic start_cmd(input pool_pkg::op_t o, input int k, input int s, input int sd,
		input int ch, input int src, input int dst, input logic track);
		int m;
		@(posedge clk);
		#2;
		op = o;
		kernel = 8'(k);
		stride = 8'(s);
		side = 8'(sd);
		channels = 16'(ch);
		src_addr = 30'(src);
		dst_addr = 30'(dst);
		start = 1'b1;
		if (track) begin
			reads = 0;
			writes = 0;
			ksq = k * k;
			next_wr = 30'(dst);
			cur_src = src;
			cur_sd = sd;
			cur_ch = ch;
			cur_k = k;
			cur_s = s;
			for (m = 0; m < 1024; m++) begin
				dma_i.res_mem[m] = 16'h7e00;
				dma_i.wr_cnt[m] = 0;
			end
		end
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic finish_cmd(input logic want_err, input int k, input int s, input int sd,
		input int ch, input int src, input int dst);
		int cycles;
		int os;
		int oy;
		int ox;
		int c;
		int a;
		pool_pkg::fp16_t want;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles == 1) begin
				assert (busy) else begin
					proto_errs++;
					$display("o_busy low one cycle after i_start at %0t ns", $time);
				end
			end
		end while (!done && cycles < TIMEOUT);
		if (!done) begin
			proto_errs++;
			stalled = 1'b1;
			$display("timed out after %0d cycles waiting for o_done", cycles);
		end else begin
			assert (op_error == want_err && !busy) else begin
				proto_errs++;
				$display("wrong o_op_error or o_busy with o_done at %0t ns", $time);
			end
			if (want_err) begin
				assert (cycles == 2 && reads == 0 && writes == 0) else begin
					proto_errs++;
					$display("refused command took %0d cycles or made DMA traffic", cycles);
				end
			end else begin
				os = (sd - k) / s + 1;
				assert (writes == os * os * ch) else begin
					proto_errs++;
					$display("o_done after %0d writes instead of %0d", writes, os * os * ch);
				end
				for (oy = 0; oy < os; oy++)
					for (ox = 0; ox < os; ox++)
						for (c = 0; c < ch; c++) begin
							a = dst + (oy * os + ox) * ch + c;
							want = ref_max(src, sd, ch, k, s, oy, ox, c);
							assert (dma_i.res_mem[a] == want && dma_i.wr_cnt[a] == 1) else begin
								value_errs++;
								$display("error %0t ns o_wr_data @%h: got %h, expected %h, %0d writes",
									$time, a, dma_i.res_mem[a], want, dma_i.wr_cnt[a]);
							end
						end
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		op = pool_pkg::MAX_POOL;
		kernel = '0;
		stride = '0;
		side = '0;
		channels = '0;
		src_addr = '0;
		dst_addr = '0;
		throttle = 1'b0;
		value_errs = 0;
		proto_errs = 0;
		reads = 0;
		writes = 0;
		done_cnt = 0;
		ksq = 0;
		next_wr = '0;
		stalled = 1'b0;
		cur_src = 0;
		cur_sd = 1;
		cur_ch = 1;
		cur_k = 1;
		cur_s = 1;
		for (n = 0; n < 1024; n++)
			dma_i.mem[n] = map_word(n);
		// 3x3 map at 0 with channel 0 negative, channel 1 zeros only, channel 2 one -0 in negatives
		for (n = 0; n < 9; n++) begin
			dma_i.mem[n * 8] = map_word(n) | 16'h8000;
			dma_i.mem[n * 8 + 1] = {~n[0], 15'd0};
			dma_i.mem[n * 8 + 2] = (n == 4) ? 16'h8000 : (map_word(n + 500) | 16'h8000);
		end
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		assert (!busy && !done && !op_error && !rd_req && !wr_valid) else begin
			proto_errs++;
			$display("control outputs not low after reset at %0t ns", $time);
		end

		start_cmd(pool_pkg::MAX_POOL, 3, 2, 3, 8, 'h000, 'h300, 1'b1);
		finish_cmd(1'b0, 3, 2, 3, 8, 'h000, 'h300);
		if (!stalled) begin
			start_cmd(pool_pkg::MAX_POOL, 3, 2, 9, 2, 'h100, 'h340, 1'b1);
			finish_cmd(1'b0, 3, 2, 9, 2, 'h100, 'h340);
		end
		if (!stalled) begin
			throttle = 1'b1;
			start_cmd(pool_pkg::MAX_POOL, 3, 2, 9, 2, 'h100, 'h380, 1'b1);
			finish_cmd(1'b0, 3, 2, 9, 2, 'h100, 'h380);
			throttle = 1'b0;
		end
		if (!stalled) begin
			start_cmd(pool_pkg::CONV, 2, 1, 3, 1, 'h000, 'h300, 1'b1);
			finish_cmd(1'b1, 2, 1, 3, 1, 'h000, 'h300);
			start_cmd(pool_pkg::AVG_POOL, 2, 1, 3, 1, 'h000, 'h300, 1'b1);
			finish_cmd(1'b1, 2, 1, 3, 1, 'h000, 'h300);
			start_cmd(pool_pkg::MAX_POOL, 4, 1, 3, 1, 'h000, 'h300, 1'b1);
			finish_cmd(1'b1, 4, 1, 3, 1, 'h000, 'h300);
		end
		if (!stalled) begin
			start_cmd(pool_pkg::MAX_POOL, 3, 2, 9, 2, 'h100, 'h3c0, 1'b1);
			d0 = done_cnt;
			// Second start lands mid-command and must be dropped
			start_cmd(pool_pkg::MAX_POOL, 2, 1, 3, 8, 'h000, 'h3e0, 1'b0);
			finish_cmd(1'b0, 3, 2, 9, 2, 'h100, 'h3c0);
			repeat (30) @(posedge clk);
			assert (done_cnt == d0 + 1) else begin
				proto_errs++;
				$display("start while busy gave %0d o_done pulses", done_cnt - d0);
			end
		end

		$display("checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== pool_engine.f ====
+incdir+source
source/pool_pkg.sv
source/pool_sync_fifo.sv
source/pool_cmd_decode.sv
source/pool_window_exec.sv
source/pool_result_writer.sv
source/pool_engine.sv
tests/pool_dma_model.sv
tests/pool_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pool engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f pool_engine.f --top-module pool_engine_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vpool_engine_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
